// File: verilog/mips_pkg.sv
`default_nettype none

package mips_pkg;

    // data, address and instruction word
    typedef logic [31:0] word_t;
    // register number
    typedef logic [4:0] creg_addr_t;
    // debug trace byte write enable
    typedef logic [3:0] rwen_t;
    // memory byte lane mask
    typedef logic [3:0] strb_t;
    // bus transfer size, 0 byte and 2 word
    typedef logic [1:0] size_t;

    typedef enum logic [3:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_AND,
        ALU_OR,
        ALU_XOR,
        ALU_SLT,
        ALU_SLTU,
        ALU_LUI
    } alu_op_t;

    // one instruction at a time, no overlap between states
    typedef enum logic [2:0] {
        S_FETCH,
        S_DECODE,
        S_EXECUTE,
        S_MEM,
        S_WB
    } seq_state_t;

    // primary opcodes
    localparam logic [5:0] OP_SPECIAL = 6'h00;
    localparam logic [5:0] OP_BEQ     = 6'h04;
    localparam logic [5:0] OP_BNE     = 6'h05;
    localparam logic [5:0] OP_ADDIU   = 6'h09;
    localparam logic [5:0] OP_ANDI    = 6'h0c;
    localparam logic [5:0] OP_ORI     = 6'h0d;
    localparam logic [5:0] OP_LUI     = 6'h0f;
    localparam logic [5:0] OP_LB      = 6'h20;
    localparam logic [5:0] OP_LW      = 6'h23;
    localparam logic [5:0] OP_LBU     = 6'h24;
    localparam logic [5:0] OP_SB      = 6'h28;
    localparam logic [5:0] OP_SW      = 6'h2b;

    // funct codes under OP_SPECIAL
    localparam logic [5:0] FN_ADDU = 6'h21;
    localparam logic [5:0] FN_SUBU = 6'h23;
    localparam logic [5:0] FN_AND  = 6'h24;
    localparam logic [5:0] FN_OR   = 6'h25;
    localparam logic [5:0] FN_XOR  = 6'h26;
    localparam logic [5:0] FN_SLT  = 6'h2a;
    localparam logic [5:0] FN_SLTU = 6'h2b;

endpackage

`default_nettype wire

// File: verilog/mips_handshake.sv
`timescale 1ns/1ns
`default_nettype none

module mips_handshake (
    input  logic clk,
    input  logic rst_n,
    // held high by the core until done
    input  logic cpu_req,
    input  logic addr_ok,
    input  logic data_ok,
    output logic req,
    output logic done
);

    typedef enum logic [1:0] {
        HS_IDLE,
        HS_ADDR,
        HS_DATA
    } hs_state_t;

    hs_state_t state;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state <= HS_IDLE;
        end else begin
            case (state)
                // registered start, so req rises one clock after cpu_req
                HS_IDLE: if (cpu_req) state <= HS_ADDR;
                // address accepted, req drops next cycle
                HS_ADDR: if (addr_ok) state <= HS_DATA;
                HS_DATA: if (data_ok) state <= HS_IDLE;
                default: state <= HS_IDLE;
            endcase
        end
    end

    assign req = (state == HS_ADDR);
    // rdata valid in this same cycle
    assign done = (state == HS_DATA) && data_ok;

    // core request stays up for the whole transaction
    a_cpu_req_held: assert property (@(posedge clk) disable iff (!rst_n)
        state != HS_IDLE |-> cpu_req);

    // no response without an accepted address, never with addr_ok
    a_no_stray_data_ok: assert property (@(posedge clk) disable iff (!rst_n)
        state != HS_DATA |-> !data_ok);

endmodule

`default_nettype wire

// File: verilog/mips_regfile.sv
`timescale 1ns/1ns
`default_nettype none

module mips_regfile (
    input  logic               clk,
    input  logic               rst_n,
    input  mips_pkg::creg_addr_t ra1,
    input  mips_pkg::creg_addr_t ra2,
    input  logic               we,
    input  mips_pkg::creg_addr_t wa,
    input  mips_pkg::word_t    wd,
    output mips_pkg::word_t    rd1,
    output mips_pkg::word_t    rd2
);

    mips_pkg::word_t regs [32];

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int i = 0; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (we && (wa != 5'd0)) begin
            // $zero never written, stays at its reset value
            regs[wa] <= wd;
        end
    end

    // combinational read
    assign rd1 = regs[ra1];
    assign rd2 = regs[ra2];

endmodule

`default_nettype wire

// File: verilog/mips_decode.sv
`timescale 1ns/1ns
`default_nettype none

module mips_decode (
    input  mips_pkg::word_t      instr,
    output mips_pkg::creg_addr_t rs,
    output mips_pkg::creg_addr_t rt,
    output mips_pkg::creg_addr_t wa,
    output mips_pkg::word_t      imm_ext,
    output mips_pkg::alu_op_t    alu_op,
    output logic                 use_imm,
    output logic                 reg_write,
    output logic                 is_load,
    output logic                 is_store,
    output logic                 is_byte,
    output logic                 load_signed,
    output logic                 is_beq,
    output logic                 is_bne
);

    logic [5:0] opcode;
    logic [5:0] funct;
    logic       zero_ext;

    assign opcode = instr[31:26];
    assign funct  = instr[5:0];
    assign rs     = instr[25:21];
    assign rt     = instr[20:16];

    // rd for R-type, rt for everything else
    assign wa = (opcode == mips_pkg::OP_SPECIAL) ? instr[15:11] : instr[20:16];

    // logical immediates zero extend
    assign zero_ext = (opcode == mips_pkg::OP_ANDI) || (opcode == mips_pkg::OP_ORI);
    assign imm_ext  = zero_ext ? {16'h0000, instr[15:0]} : {{16{instr[15]}}, instr[15:0]};

    always_comb begin
        // unknown encodings fall through as no-ops
        alu_op      = mips_pkg::ALU_ADD;
        use_imm     = 1'b0;
        reg_write   = 1'b0;
        is_load     = 1'b0;
        is_store    = 1'b0;
        is_byte     = 1'b0;
        load_signed = 1'b0;
        is_beq      = 1'b0;
        is_bne      = 1'b0;
        case (opcode)
            mips_pkg::OP_SPECIAL: begin
                reg_write = 1'b1;
                case (funct)
                    mips_pkg::FN_ADDU: alu_op = mips_pkg::ALU_ADD;
                    mips_pkg::FN_SUBU: alu_op = mips_pkg::ALU_SUB;
                    mips_pkg::FN_AND:  alu_op = mips_pkg::ALU_AND;
                    mips_pkg::FN_OR:   alu_op = mips_pkg::ALU_OR;
                    mips_pkg::FN_XOR:  alu_op = mips_pkg::ALU_XOR;
                    mips_pkg::FN_SLT:  alu_op = mips_pkg::ALU_SLT;
                    mips_pkg::FN_SLTU: alu_op = mips_pkg::ALU_SLTU;
                    default:           reg_write = 1'b0;
                endcase
            end
            mips_pkg::OP_ADDIU: begin
                use_imm   = 1'b1;
                reg_write = 1'b1;
            end
            mips_pkg::OP_ANDI: begin
                alu_op    = mips_pkg::ALU_AND;
                use_imm   = 1'b1;
                reg_write = 1'b1;
            end
            mips_pkg::OP_ORI: begin
                alu_op    = mips_pkg::ALU_OR;
                use_imm   = 1'b1;
                reg_write = 1'b1;
            end
            mips_pkg::OP_LUI: begin
                alu_op    = mips_pkg::ALU_LUI;
                use_imm   = 1'b1;
                reg_write = 1'b1;
            end
            // loads and stores add the offset to rs
            mips_pkg::OP_LW, mips_pkg::OP_LB, mips_pkg::OP_LBU: begin
                use_imm     = 1'b1;
                reg_write   = 1'b1;
                is_load     = 1'b1;
                is_byte     = (opcode != mips_pkg::OP_LW);
                load_signed = (opcode == mips_pkg::OP_LB);
            end
            mips_pkg::OP_SW, mips_pkg::OP_SB: begin
                use_imm  = 1'b1;
                is_store = 1'b1;
                is_byte  = (opcode == mips_pkg::OP_SB);
            end
            mips_pkg::OP_BEQ: is_beq = 1'b1;
            mips_pkg::OP_BNE: is_bne = 1'b1;
            default: ;
        endcase
    end

endmodule

`default_nettype wire

// File: verilog/mips_execute.sv
`timescale 1ns/1ns
`default_nettype none

module mips_execute (
    input  mips_pkg::word_t   pc,
    input  mips_pkg::word_t   a,
    input  mips_pkg::word_t   b,
    input  mips_pkg::word_t   imm_ext,
    input  mips_pkg::alu_op_t alu_op,
    input  logic              use_imm,
    input  logic              is_beq,
    input  logic              is_bne,
    input  logic              is_byte,
    input  logic              is_store,
    output mips_pkg::word_t   alu_y,
    output logic              branch_taken,
    output mips_pkg::word_t   branch_target,
    output mips_pkg::strb_t   store_strb,
    output mips_pkg::word_t   store_data
);

    mips_pkg::word_t b_in;
    logic            equal;

    assign b_in = use_imm ? imm_ext : b;

    always_comb begin
        case (alu_op)
            mips_pkg::ALU_ADD:  alu_y = a + b_in;
            mips_pkg::ALU_SUB:  alu_y = a - b_in;
            mips_pkg::ALU_AND:  alu_y = a & b_in;
            mips_pkg::ALU_OR:   alu_y = a | b_in;
            mips_pkg::ALU_XOR:  alu_y = a ^ b_in;
            mips_pkg::ALU_SLT:  alu_y = {31'd0, $signed(a) < $signed(b_in)};
            mips_pkg::ALU_SLTU: alu_y = {31'd0, a < b_in};
            // immediate moved into the upper half
            mips_pkg::ALU_LUI:  alu_y = {b_in[15:0], 16'h0000};
            default:            alu_y = a + b_in;
        endcase
    end

    // branches compare the two registers, never the immediate
    assign equal         = (a == b);
    assign branch_taken  = (is_beq && equal) || (is_bne && !equal);
    assign branch_target = pc + 32'd4 + {imm_ext[29:0], 2'b00};

    // byte store hits one lane picked by the address low bits
    always_comb begin
        if (!is_store) begin
            store_strb = 4'b0000;
        end else if (is_byte) begin
            store_strb = 4'b0001 << alu_y[1:0];
        end else begin
            store_strb = 4'b1111;
        end
    end

    assign store_data = is_byte ? {4{b[7:0]}} : b;

endmodule

`default_nettype wire

// File: verilog/mips_result.sv
`timescale 1ns/1ns
`default_nettype none

module mips_result (
    input  mips_pkg::word_t alu_y,
    input  mips_pkg::word_t load_word,
    input  logic            is_load,
    input  logic            is_byte,
    input  logic            load_signed,
    output mips_pkg::word_t wd
);

    logic [7:0]      lane;
    mips_pkg::word_t load_val;

    // alu_y holds the load address here
    always_comb begin
        case (alu_y[1:0])
            2'd0:    lane = load_word[7:0];
            2'd1:    lane = load_word[15:8];
            2'd2:    lane = load_word[23:16];
            default: lane = load_word[31:24];
        endcase
    end

    always_comb begin
        if (!is_byte) begin
            load_val = load_word;
        end else if (load_signed) begin
            load_val = {{24{lane[7]}}, lane};
        end else begin
            load_val = {24'd0, lane};
        end
    end

    assign wd = is_load ? load_val : alu_y;

endmodule

`default_nettype wire

// File: verilog/mips_datapath.sv
`timescale 1ns/1ns
`default_nettype none

module mips_datapath #(
    parameter mips_pkg::word_t RESET_PC = 32'hbfc0_0000
) (
    input  logic                 clk,
    input  logic                 rst_n,
    input  logic                 fetch_done,
    input  mips_pkg::word_t      instr_in,
    input  logic                 mem_done,
    input  mips_pkg::word_t      mem_rdata,
    output mips_pkg::word_t      pc,
    output logic                 fetch_req,
    output logic                 mem_req,
    output logic                 mem_wr,
    output mips_pkg::word_t      mem_addr,
    output mips_pkg::size_t      mem_size,
    output mips_pkg::word_t      mem_wdata,
    output mips_pkg::word_t      wb_pc,
    output logic                 wb_wen,
    output mips_pkg::creg_addr_t wb_wnum,
    output mips_pkg::word_t      wb_wdata
);

    mips_pkg::seq_state_t state;

    // instruction, its pc, operands and latches
    mips_pkg::word_t ir, ir_pc, a_q, b_q, alu_q, sdata_q, load_q;
    mips_pkg::strb_t strb_q;

    mips_pkg::creg_addr_t rs, rt, wa;
    mips_pkg::word_t      imm_ext, rd1, rd2, alu_y, branch_target, store_data, wd;
    mips_pkg::alu_op_t    alu_op;
    mips_pkg::strb_t      store_strb;
    logic use_imm, reg_write, is_load, is_store, is_byte, load_signed;
    logic is_beq, is_bne, branch_taken, rf_we;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state  <= mips_pkg::S_FETCH;
            pc     <= RESET_PC;
            strb_q <= '0;
        end else begin
            case (state)
                // wait as long as the instruction port stalls
                mips_pkg::S_FETCH: if (fetch_done) state <= mips_pkg::S_DECODE;
                mips_pkg::S_DECODE: state <= mips_pkg::S_EXECUTE;
                mips_pkg::S_EXECUTE: begin
                    // no delay slot, next fetch already goes to the target
                    pc     <= branch_taken ? branch_target : pc + 32'd4;
                    strb_q <= store_strb;
                    state  <= (is_load || is_store) ? mips_pkg::S_MEM : mips_pkg::S_WB;
                end
                mips_pkg::S_MEM: if (mem_done) state <= mips_pkg::S_WB;
                default: state <= mips_pkg::S_FETCH;
            endcase
        end
    end

    // payload latches
    always_ff @(posedge clk) begin
        if (state == mips_pkg::S_FETCH && fetch_done) begin
            ir    <= instr_in;
            ir_pc <= pc;
        end
        if (state == mips_pkg::S_DECODE) begin
            a_q <= rd1;
            b_q <= rd2;
        end
        if (state == mips_pkg::S_EXECUTE) begin
            alu_q   <= alu_y;
            sdata_q <= store_data;
        end
        if (state == mips_pkg::S_MEM && mem_done) begin
            load_q <= mem_rdata;
        end
    end

    mips_decode u_decode (
        .instr(ir), .rs(rs), .rt(rt), .wa(wa), .imm_ext(imm_ext), .alu_op(alu_op),
        .use_imm(use_imm), .reg_write(reg_write), .is_load(is_load), .is_store(is_store),
        .is_byte(is_byte), .load_signed(load_signed), .is_beq(is_beq), .is_bne(is_bne)
    );

    mips_execute u_execute (
        .pc(ir_pc), .a(a_q), .b(b_q), .imm_ext(imm_ext), .alu_op(alu_op),
        .use_imm(use_imm), .is_beq(is_beq), .is_bne(is_bne), .is_byte(is_byte),
        .is_store(is_store), .alu_y(alu_y), .branch_taken(branch_taken),
        .branch_target(branch_target), .store_strb(store_strb), .store_data(store_data)
    );

    mips_result u_result (
        .alu_y(alu_q), .load_word(load_q), .is_load(is_load), .is_byte(is_byte),
        .load_signed(load_signed), .wd(wd)
    );

    // write only in the single writeback cycle
    assign rf_we = (state == mips_pkg::S_WB) && reg_write;

    mips_regfile u_regfile (
        .clk(clk), .rst_n(rst_n), .ra1(rs), .ra2(rt), .we(rf_we), .wa(wa), .wd(wd),
        .rd1(rd1), .rd2(rd2)
    );

    assign fetch_req = (state == mips_pkg::S_FETCH);
    assign mem_req   = (state == mips_pkg::S_MEM);
    // any lane set means a store
    assign mem_wr    = |strb_q;
    assign mem_addr  = alu_q;
    assign mem_size  = is_byte ? 2'd0 : 2'd2;
    assign mem_wdata = sdata_q;

    // trace port, enable only for nonzero destinations
    assign wb_pc    = ir_pc;
    assign wb_wen   = rf_we && (wa != 5'd0);
    assign wb_wnum  = wa;
    assign wb_wdata = wd;

    // completions only come back to the state that asked
    a_fetch_done_in_fetch: assert property (@(posedge clk) disable iff (!rst_n)
        fetch_done |-> state == mips_pkg::S_FETCH);

    a_mem_done_in_mem: assert property (@(posedge clk) disable iff (!rst_n)
        mem_done |-> state == mips_pkg::S_MEM);

    a_pc_aligned: assert property (@(posedge clk) disable iff (!rst_n)
        pc[1:0] == 2'b00);

endmodule

`default_nettype wire

// File: verilog/mycpu.sv
`timescale 1ns/1ns
`default_nettype none

module mycpu #(
    parameter mips_pkg::word_t RESET_PC = 32'hbfc0_0000
) (
    input  logic                 clk,
    input  logic                 rst_n,

    // instruction port, read only
    output logic                 inst_req,
    output logic                 inst_wr,
    output mips_pkg::size_t      inst_size,
    output mips_pkg::word_t      inst_addr,
    output mips_pkg::word_t      inst_wdata,
    input  mips_pkg::word_t      inst_rdata,
    input  logic                 inst_addr_ok,
    input  logic                 inst_data_ok,

    // data port
    output logic                 data_req,
    output logic                 data_wr,
    output mips_pkg::size_t      data_size,
    output mips_pkg::word_t      data_addr,
    output mips_pkg::word_t      data_wdata,
    input  mips_pkg::word_t      data_rdata,
    input  logic                 data_addr_ok,
    input  logic                 data_data_ok,

    // writeback trace
    output mips_pkg::word_t      debug_wb_pc,
    output mips_pkg::rwen_t      debug_wb_rf_wen,
    output mips_pkg::creg_addr_t debug_wb_rf_wnum,
    output mips_pkg::word_t      debug_wb_rf_wdata
);

    logic fetch_req, fetch_done, mem_req, mem_done, wb_wen;

    mips_datapath #(
        .RESET_PC(RESET_PC)
    ) u_datapath (
        .clk(clk), .rst_n(rst_n), .fetch_done(fetch_done), .instr_in(inst_rdata),
        .mem_done(mem_done), .mem_rdata(data_rdata), .pc(inst_addr),
        .fetch_req(fetch_req), .mem_req(mem_req), .mem_wr(data_wr), .mem_addr(data_addr),
        .mem_size(data_size), .mem_wdata(data_wdata), .wb_pc(debug_wb_pc),
        .wb_wen(wb_wen), .wb_wnum(debug_wb_rf_wnum), .wb_wdata(debug_wb_rf_wdata)
    );

    // fetches are always full word reads
    assign inst_wr    = 1'b0;
    assign inst_size  = 2'd2;
    assign inst_wdata = '0;

    mips_handshake i_handshake (
        .clk(clk), .rst_n(rst_n), .cpu_req(fetch_req), .addr_ok(inst_addr_ok),
        .data_ok(inst_data_ok), .req(inst_req), .done(fetch_done)
    );

    mips_handshake d_handshake (
        .clk(clk), .rst_n(rst_n), .cpu_req(mem_req), .addr_ok(data_addr_ok),
        .data_ok(data_data_ok), .req(data_req), .done(mem_done)
    );

    assign debug_wb_rf_wen = {4{wb_wen}};

endmodule

`default_nettype wire

// File: test/tb_mycpu.sv
`timescale 1ns/1ns
`default_nettype none

module tb_mycpu;

    localparam logic [31:0] RESET_PC   = 32'hbfc0_0000;
    localparam logic [31:0] SEED       = 32'hc7d8dcb8;
    localparam int          VEC_MAX    = 128;
    localparam int          DMEM_WORDS = 16;

    logic clk;
    logic rst_n;

    // index 0 is the instruction port, 1 the data port
    logic        p_req   [2];
    logic        p_wr    [2];
    logic [1:0]  p_size  [2];
    logic [31:0] p_addr  [2];
    logic [31:0] p_wdata [2];
    logic [31:0] p_rdata [2];
    logic        p_aok   [2];
    logic        p_dok   [2];

    logic [31:0] debug_wb_pc;
    logic [3:0]  debug_wb_rf_wen;
    logic [4:0]  debug_wb_rf_wnum;
    logic [31:0] debug_wb_rf_wdata;

    logic [31:0] vec  [VEC_MAX];
    logic [31:0] dmem [DMEM_WORDS];

    // slave side of each port: 0 idle, 1 address wait, 2 data wait
    int          phase    [2];
    int          wait_cnt [2];
    logic [31:0] acc_addr [2];
    logic        acc_wr   [2];
    logic [1:0]  acc_size [2];
    logic [31:0] acc_wdata[2];

    logic [31:0] rng;
    logic [31:0] end_pc;
    int n_prog, n_trace, n_data, trace_base, data_base, trace_idx;
    int err_reset, err_trace, err_mem, err_bus, tests_failed;
    logic loaded, first_fetch_seen, end_seen;

    mycpu #(
        .RESET_PC(RESET_PC)
    ) i_dut (
        .clk(clk), .rst_n(rst_n),
        .inst_req(p_req[0]), .inst_wr(p_wr[0]), .inst_size(p_size[0]),
        .inst_addr(p_addr[0]), .inst_wdata(p_wdata[0]), .inst_rdata(p_rdata[0]),
        .inst_addr_ok(p_aok[0]), .inst_data_ok(p_dok[0]),
        .data_req(p_req[1]), .data_wr(p_wr[1]), .data_size(p_size[1]),
        .data_addr(p_addr[1]), .data_wdata(p_wdata[1]), .data_rdata(p_rdata[1]),
        .data_addr_ok(p_aok[1]), .data_data_ok(p_dok[1]),
        .debug_wb_pc(debug_wb_pc), .debug_wb_rf_wen(debug_wb_rf_wen),
        .debug_wb_rf_wnum(debug_wb_rf_wnum), .debug_wb_rf_wdata(debug_wb_rf_wdata)
    );

    always #20 clk = ~clk;

    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    // 0 to 3 cycles of delay
    function automatic int draw_delay();
        rng = xorshift32(rng);
        return int'(rng % 32'd4);
    endfunction

    function automatic logic [31:0] fill_word(input logic [31:0] addr);
        return {~addr[15:0], addr[15:0]} ^ {addr[31:16], addr[31:16]} ^ 32'h3c5a_0000;
    endfunction

    function automatic logic [31:0] instr_word(input logic [31:0] addr);
        logic [31:0] idx;
        idx = (addr - RESET_PC) >> 2;
        // past the image reads as a no-op
        if (idx < 32'(n_prog)) begin
            return vec[3 + int'(idx)];
        end
        return 32'h0;
    endfunction

    // carried out in the cycle that raises data_ok
    task automatic complete_access(input int p);
        int idx;
        int lane;
        idx  = int'(acc_addr[p][5:2]);
        lane = int'(acc_addr[p][1:0]);
        if (p == 0) begin
            p_rdata[0] <= instr_word(acc_addr[0]);
        end else if (acc_addr[1] >= 32'(DMEM_WORDS * 4)) begin
            $display("%0t: data access outside the data memory at %h", $time, acc_addr[1]);
            err_bus++;
        end else if (acc_wr[1]) begin
            if (acc_size[1] == 2'd2) begin
                dmem[idx] = acc_wdata[1];
            end else begin
                dmem[idx][8*lane +: 8] = acc_wdata[1][8*lane +: 8];
            end
        end else begin
            p_rdata[1] <= dmem[idx];
        end
    endtask

    task automatic accept_address(input int p);
        p_aok[p] <= 1'b0;
        acc_addr[p]  = p_addr[p];
        acc_wr[p]    = p_wr[p];
        acc_size[p]  = p_size[p];
        acc_wdata[p] = p_wdata[p];
        if (p == 0) begin
            if (!first_fetch_seen && p_addr[0] != RESET_PC) begin
                $display("MISMATCH %0t: first fetch at %h, expected %h",
                         $time, p_addr[0], RESET_PC);
                err_reset++;
            end
            // fetches are plain word reads
            if (p_wr[0] != 1'b0 || p_size[0] != 2'd2 || p_wdata[0] != 32'h0) begin
                $display("MISMATCH %0t: fetch wr %b size %0d wdata %h, expected 0 2 0",
                         $time, p_wr[0], p_size[0], p_wdata[0]);
                err_bus++;
            end
            first_fetch_seen = 1'b1;
            if (p_addr[0] == end_pc) begin
                end_seen = 1'b1;
            end
        end
        phase[p]    = 2;
        wait_cnt[p] = draw_delay();
        if (wait_cnt[p] == 0) begin
            p_dok[p] <= 1'b1;
            complete_access(p);
        end
    endtask

    task automatic serve_port(input int p);
        if (phase[p] == 0) begin
            if (p_req[p]) begin
                phase[p]    = 1;
                wait_cnt[p] = draw_delay();
                if (wait_cnt[p] == 0) begin
                    p_aok[p] <= 1'b1;
                end
            end
        end else if (phase[p] == 1) begin
            if (p_aok[p]) begin
                accept_address(p);
            end else if (!p_req[p]) begin
                $display("%0t: port %0d dropped its request before addr_ok", $time, p);
                err_bus++;
                phase[p] = 0;
            end else if (wait_cnt[p] > 0) begin
                wait_cnt[p]--;
                if (wait_cnt[p] == 0) begin
                    p_aok[p] <= 1'b1;
                end
            end
        end else begin
            if (p_req[p]) begin
                $display("%0t: port %0d raised a new request before data_ok", $time, p);
                err_bus++;
            end
            if (p_dok[p]) begin
                p_dok[p] <= 1'b0;
                phase[p] = 0;
            end else if (wait_cnt[p] > 0) begin
                wait_cnt[p]--;
                if (wait_cnt[p] == 0) begin
                    p_dok[p] <= 1'b1;
                    complete_access(p);
                end
            end
        end
    endtask

    always @(posedge clk) begin
        if (rst_n) begin
            for (int p = 0; p < 2; p++) begin
                serve_port(p);
            end
        end
    end

    task automatic check_writeback();
        int base;
        if (debug_wb_rf_wnum == 5'd0) begin
            $display("%0t: write enable raised for register 0", $time);
            err_trace++;
        end
        if (trace_idx >= n_trace) begin
            $display("%0t: writeback past the end of the trace at pc %h", $time, debug_wb_pc);
            err_trace++;
        end else begin
            base = trace_base + 3 * trace_idx;
            if (debug_wb_rf_wen != 4'hf) begin
                $display("MISMATCH %0t: wen %h, expected f", $time, debug_wb_rf_wen);
                err_trace++;
            end
            if (debug_wb_pc != vec[base] || debug_wb_rf_wnum != vec[base + 1][4:0]
                    || debug_wb_rf_wdata != vec[base + 2]) begin
                $display("MISMATCH %0t: entry %0d got pc %h r%0d %h, expected pc %h r%0d %h",
                         $time, trace_idx, debug_wb_pc, debug_wb_rf_wnum, debug_wb_rf_wdata,
                         vec[base], vec[base + 1], vec[base + 2]);
                err_trace++;
            end
            trace_idx++;
        end
    endtask

    always @(posedge clk) begin
        if (rst_n && debug_wb_rf_wen != 4'h0) begin
            check_writeback();
        end
    end

    task automatic report_test(input string name, input int errs);
        if (errs == 0) begin
            $display("%s: ok", name);
        end else begin
            $display("%s: %0d errors", name, errs);
            tests_failed++;
        end
    endtask

    // limit scales with program and trace length
    initial begin
        wait (loaded);
        #((n_prog + n_trace) * 40 * 40 + 10 * 40);
        $display("timeout: the program never reached its final instruction");
        $display("TEST FAILED");
        $finish;
    end

    initial begin
        clk   = 1'b0;
        rst_n = 1'b0;
        rng   = SEED;
        for (int p = 0; p < 2; p++) begin
            p_aok[p]   = 1'b0;
            p_dok[p]   = 1'b0;
            p_rdata[p] = 32'h0;
            phase[p]   = 0;
            wait_cnt[p] = 0;
        end
        for (int i = 0; i < DMEM_WORDS; i++) begin
            dmem[i] = fill_word(32'(i * 4));
        end
        trace_idx = 0;
        err_reset = 0;
        err_trace = 0;
        err_mem   = 0;
        err_bus   = 0;
        tests_failed     = 0;
        first_fetch_seen = 1'b0;
        end_seen         = 1'b0;
        $readmemh("test/mycpu_vectors.txt", vec);
        n_prog     = int'(vec[0]);
        n_trace    = int'(vec[1]);
        n_data     = int'(vec[2]);
        trace_base = 3 + n_prog;
        data_base  = trace_base + 3 * n_trace;
        end_pc     = RESET_PC + 32'(4 * (n_prog - 1));
        loaded     = 1'b1;

        repeat (10) begin
            @(posedge clk);
            if (p_req[0] || p_req[1]) begin
                $display("%0t: bus request raised during reset", $time);
                err_reset++;
            end
        end
        rst_n <= 1'b1;
        wait (first_fetch_seen);
        report_test("reset", err_reset);

        wait (end_seen);
        @(posedge clk);
        if (trace_idx != n_trace) begin
            $display("%0t: only %0d of %0d trace entries retired", $time, trace_idx, n_trace);
            err_trace++;
        end
        report_test("writeback trace", err_trace);
        for (int i = 0; i < n_data; i++) begin
            if (dmem[vec[data_base + 2*i][5:2]] != vec[data_base + 2*i + 1]) begin
                $display("MISMATCH %0t: word at %h is %h, expected %h", $time,
                         vec[data_base + 2*i], dmem[vec[data_base + 2*i][5:2]],
                         vec[data_base + 2*i + 1]);
                err_mem++;
            end
        end
        report_test("final data memory", err_mem);
        report_test("bus protocol", err_bus);
        $display("4 tests, %0d failed, %0d errors", tests_failed,
                 err_reset + err_trace + err_mem + err_bus);
        if (tests_failed == 0) begin
            $display("TEST PASSED");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: mycpu.f
verilog/mips_pkg.sv
verilog/mips_handshake.sv
verilog/mips_regfile.sv
verilog/mips_decode.sv
verilog/mips_execute.sv
verilog/mips_result.sv
verilog/mips_datapath.sv
verilog/mycpu.sv
test/tb_mycpu.sv

// File: Makefile
# Verilator build and run for the mycpu testbench

VERILATOR ?= verilator
TOP       ?= tb_mycpu
FILELIST  ?= mycpu.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary --timing --assert -Wno-fatal
LINTFLAGS ?= --lint-only --timing

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FILELIST)

# pass only when the simulation prints the pass line
run: build
	@out="$$(./$(BUILD_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "^TEST PASSED$$"

lint:
	$(VERILATOR) $(LINTFLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(BUILD_DIR)

// File: test/mycpu_vectors.txt
// header: program words, trace entries, final data words
// then program from RESET_PC, trace (pc reg value), final data (addr value)
1a 0e 03
3c011234 34215678 2402ffff 304300f0
00232021 00612823 00223026 0043382a
0043402b 00674825 00210021 ac010000
ac060004 a0020001 8c0a0000 800b0004
900c0006 102a0001 142a0001 240d0bad
10210001 240d0bad 14630001 25ad0001
ac0d0008 1000ffff
bfc00000 01 12340000
bfc00004 01 12345678
bfc00008 02 ffffffff
bfc0000c 03 000000f0
bfc00010 04 12345768
bfc00014 05 edcbaa78
bfc00018 06 edcba987
bfc0001c 07 00000001
bfc00020 08 00000000
bfc00024 09 000000f1
bfc00038 0a 1234ff78
bfc0003c 0b ffffff87
bfc00040 0c 000000cb
bfc0005c 0d 00000001
00000000 1234ff78
00000004 edcba987
00000008 00000001
